// File: sources.f
verilog/rv32DecodePkg.sv
verilog/immGen.sv
verilog/controlDecode.sv
verilog/aluDecode.sv
verilog/decodeStage.sv
dv/decodeChecker.sv
dv/decodeTb.sv

// File: Bender.yml
package:
  name: rv32_decode

sources:
  - files:
      - verilog/rv32DecodePkg.sv
      - verilog/immGen.sv
      - verilog/controlDecode.sv
      - verilog/aluDecode.sv
      - verilog/decodeStage.sv
  - target: test
    files:
      - dv/decodeChecker.sv
      - dv/decodeTb.sv

// File: dv/decodeTb.sv
`timescale 1ns/1ps

module decodeTb
    import rv32DecodePkg::*;
();

    localparam int NumWords    = 2000;
    localparam int ResetCycles = 10;

    logic        clk;
    logic        rst;
    logic [31:0] instr;
    logic [31:0] rsValue1;
    logic [31:0] rsValue2;
    decodeOutT   dec;
    int          errorCount;
    int          checkCount;
    int          wordsChecked;
    logic [31:0] seed;
    logic        timedOut;

    decodeStage UUT (
        .clk      (clk),
        .rst      (rst),
        .instr    (instr),
        .rsValue1 (rsValue1),
        .rsValue2 (rsValue2),
        .dec      (dec)
    );

    decodeChecker uChecker (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .rsValue1     (rsValue1),
        .rsValue2     (rsValue2),
        .dec          (dec),
        .errorCount   (errorCount),
        .checkCount   (checkCount),
        .wordsChecked (wordsChecked)
    );

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Fold high bits down, LCG low bits are weak
    task automatic drawRandom(output logic [31:0] r);
        seed = lcgNext(seed);
        r = seed ^ (seed >> 13);
    endtask

    // Mostly valid opcodes, one in ten random
    task automatic nextWord(output logic [31:0] w);
        logic [31:0] pick;
        logic [31:0] body;
        logic [6:0]  opc;
        drawRandom(pick);
        drawRandom(body);
        case ((pick >> 8) % 10)
            0: opc = OPC_LUI;
            1: opc = OPC_AUIPC;
            2: opc = OPC_JAL;
            3: opc = OPC_JALR;
            4: opc = OPC_BRANCH;
            5: opc = OPC_LOAD;
            6: opc = OPC_STORE;
            7: opc = OPC_OP_IMM;
            8: opc = OPC_OP;
            default: opc = pick[30:24];
        endcase
        w = {body[31:7], opc};
        // OP gets base, alternate, M or junk func7
        if (opc == OPC_OP)
        begin
            case (pick[1:0])
                2'd0: w[31:25] = 7'b0000000;
                2'd1: w[31:25] = 7'b0100000;
                2'd2: w[31:25] = 7'b0000001;
                default: w[31:25] = body[6:0];
            endcase
        end
    endtask

    initial
    begin
        int          guard;
        logic [31:0] w;
        logic [31:0] v1;
        logic [31:0] v2;
        seed     = 32'h91a7;
        instr    = '0;
        rsValue1 = '0;
        rsValue2 = '0;
        timedOut = 1'b0;
        guard    = 0;
        while (rst !== 1'b0 && guard < 4 * ResetCycles)
        begin
            @(posedge clk);
            guard++;
        end
        if (rst !== 1'b0)
        begin
            $display("Reset was never released");
            timedOut = 1'b1;
        end
        else
        begin
            for (int i = 0; i < NumWords; i++)
            begin
                @(negedge clk);
                nextWord(w);
                drawRandom(v1);
                drawRandom(v2);
                instr    = w;
                rsValue1 = v1;
                rsValue2 = v2;
            end
            // Zero word held over the first edge after release, then every driven word
            guard = 0;
            while (wordsChecked < NumWords + 1 && guard < 20)
            begin
                @(posedge clk);
                guard++;
            end
            if (wordsChecked < NumWords + 1)
            begin
                $display("Checker did not compare every driven word in time");
                timedOut = 1'b1;
            end
        end
        $display("Errors: %0d  Checks: %0d", errorCount, checkCount);
        if (errorCount == 0 && !timedOut)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// File: dv/decodeChecker.sv
`timescale 1ns/1ps

module decodeChecker
    import rv32DecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Same inputs the DUT sees
    input  logic [31:0] instr,
    input  logic [31:0] rsValue1,
    input  logic [31:0] rsValue2,
    input  decodeOutT   dec,
    output int          errorCount,
    output int          checkCount,
    output int          wordsChecked
);

    // Inputs taken at the last rising edge
    logic [31:0] wordQ;
    logic [31:0] value1Q;
    logic [31:0] value2Q;
    logic        seenEdge;
    // Set when the captured word came from outside reset
    logic        liveQ;

    initial
    begin
        errorCount   = 0;
        checkCount   = 0;
        wordsChecked = 0;
        seenEdge     = 1'b0;
    end

    // Model register mirroring the stage's single register
    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            wordQ   <= '0;
            value1Q <= '0;
            value2Q <= '0;
            liveQ   <= 1'b0;
        end
        else
        begin
            wordQ   <= instr;
            value1Q <= rsValue1;
            value2Q <= rsValue2;
            liveQ   <= 1'b1;
        end
        seenEdge <= 1'b1;
    end

    // Nine known opcodes plus legal func7 on OP
    function automatic logic isIllegal(input logic [31:0] w);
        logic known;
        known = (w[6:0] == OPC_LUI) || (w[6:0] == OPC_AUIPC) || (w[6:0] == OPC_JAL) ||
                (w[6:0] == OPC_JALR) || (w[6:0] == OPC_BRANCH) || (w[6:0] == OPC_LOAD) ||
                (w[6:0] == OPC_STORE) || (w[6:0] == OPC_OP_IMM) || (w[6:0] == OPC_OP);
        if (!known)
            return 1'b1;
        if (w[6:0] == OPC_OP)
            return !(w[31:25] == 7'b0000000 || w[31:25] == 7'b0100000 ||
                     w[31:25] == 7'b0000001);
        return 1'b0;
    endfunction

    // ISA immediate per format with sign from bit 31
    function automatic logic [31:0] isaImmediate(input logic [31:0] w);
        case (w[6:0])
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:
                return {{20{w[31]}}, w[31:20]};
            OPC_STORE:
                return {{20{w[31]}}, w[31:25], w[11:7]};
            OPC_BRANCH:
                return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:
                return {w[31:12], 12'h000};
            OPC_JAL:
                return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:
                return 32'h0;
        endcase
    endfunction

    // Control table of the main decoder
    function automatic ctrlT controlTable(input logic [31:0] w);
        ctrlT c;
        c = '0;
        if (isIllegal(w))
            return c;
        case (w[6:0])
            OPC_LUI:
            begin
                c.aluOp    = ALUOP_LUI;
                c.aluSrc   = 1;
                c.regWrite = 1;
            end
            OPC_AUIPC:
            begin
                c.aluOp    = ALUOP_AUIPC;
                c.aluSrc   = 1;
                c.regWrite = 1;
            end
            OPC_BRANCH:
            begin
                c.aluOp  = ALUOP_BRANCH;
                c.branch = 1;
            end
            OPC_STORE:
            begin
                c.aluOp    = ALUOP_MEM;
                c.aluSrc   = 1;
                c.memWrite = 1;
            end
            OPC_OP_IMM:
            begin
                c.aluOp    = ALUOP_ARITH;
                c.aluSrc   = 1;
                c.regWrite = 1;
            end
            OPC_OP:
            begin
                c.aluOp    = ALUOP_ARITH;
                c.regWrite = 1;
            end
            OPC_LOAD:
            begin
                c.aluOp    = ALUOP_MEM;
                c.aluSrc   = 1;
                c.memRead  = 1;
                c.regWrite = 1;
                c.memToReg = 1;
            end
            default:
            begin
                // Both jumps link and redirect
                c.aluOp    = (w[6:0] == OPC_JAL) ? ALUOP_JAL : ALUOP_JALR;
                c.aluSrc   = 1;
                c.regWrite = 1;
                c.memToReg = 1;
                c.branch   = 1;
            end
        endcase
        return c;
    endfunction

    // Exact ALU op with AND for illegal words
    function automatic aluCtrlT aluOperation(input logic [31:0] w);
        logic isOp;
        isOp = (w[6:0] == OPC_OP);
        if (isIllegal(w))
            return ALU_AND;
        if (w[6:0] == OPC_BRANCH)
            return ALU_SUB;
        if (!isOp && w[6:0] != OPC_OP_IMM)
            return ALU_ADD;
        // RV32M group in func3 order
        if (isOp && w[31:25] == 7'b0000001)
        begin
            case (w[14:12])
                3'd0: return ALU_MUL;
                3'd1: return ALU_MULH;
                3'd2: return ALU_MULHSU;
                3'd3: return ALU_MULHU;
                3'd4: return ALU_DIV;
                3'd5: return ALU_DIVU;
                3'd6: return ALU_REM;
                default: return ALU_REMU;
            endcase
        end
        case (w[14:12])
            3'd0: return (isOp && w[30]) ? ALU_SUB : ALU_ADD;
            3'd1: return ALU_SLL;
            3'd2: return ALU_SLT;
            3'd3: return ALU_SLTU;
            3'd4: return ALU_XOR;
            3'd5: return w[30] ? ALU_SRA : ALU_SRL;
            3'd6: return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    task automatic checkField(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("FAILED at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    // Every field of the bundle against the model
    task automatic compareAll();
        checkField("dec.rd", wordQ[11:7], dec.rd);
        checkField("dec.rs1", wordQ[19:15], dec.rs1);
        checkField("dec.rs2", wordQ[24:20], dec.rs2);
        checkField("dec.imm", isaImmediate(wordQ), dec.imm);
        checkField("dec.ctrl", controlTable(wordQ), dec.ctrl);
        checkField("dec.aluCtrl", aluOperation(wordQ), dec.aluCtrl);
        checkField("dec.value1", value1Q, dec.value1);
        checkField("dec.value2", value2Q, dec.value2);
        checkField("dec.illegal", isIllegal(wordQ), dec.illegal);
    endtask

    // Compare on the falling edge once outputs have settled
    always @(negedge clk)
    begin
        if (seenEdge)
        begin
            compareAll();
            if (liveQ)
                wordsChecked++;
        end
    end

    // Quiet state right at release
    always @(negedge rst)
    begin
        checkField("dec.ctrl at reset release", 32'h0, dec.ctrl);
        checkField("dec.imm at reset release", 32'h0, dec.imm);
        checkField("dec.aluCtrl at reset release", ALU_AND, dec.aluCtrl);
        checkField("dec.illegal at reset release", 32'h1, dec.illegal);
    end

endmodule

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage
    import rv32DecodePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // Word fetched last cycle and register-bank reads
    input  logic [31:0] instr,
    input  logic [31:0] rsValue1,
    input  logic [31:0] rsValue2,
    // Bundle for the execute stage
    output decodeOutT   dec
);

    // Latched instruction and operands
    instrT       instrQ;
    logic [31:0] value1Q;
    logic [31:0] value2Q;

    // Sub-decoder results
    ctrlT        ctrl;
    logic        illegal;
    logic [31:0] imm;
    aluCtrlT     aluCtrl;

    // Single pipeline register, new word every cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // All-zero word decodes as illegal with quiet controls
            instrQ  <= '0;
            value1Q <= '0;
            value2Q <= '0;
        end
        else
        begin
            instrQ  <= instr;
            value1Q <= rsValue1;
            value2Q <= rsValue2;
        end
    end

    // Immediate for the format picked by the opcode
    immGen uImmGen (
        .word (instrQ),
        .imm  (imm)
    );

    // Main control and illegal flag
    controlDecode uControlDecode (
        .word    (instrQ),
        .ctrl    (ctrl),
        .illegal (illegal)
    );

    // Exact ALU op, driven by the class from the main decoder
    aluDecode uAluDecode (
        .word    (instrQ),
        .aluOp   (ctrl.aluOp),
        .aluCtrl (aluCtrl)
    );

    // Pack the output bundle
    always_comb
    begin
        // Register indices sit at the same bits in every format
        dec.rd      = instrQ.rType.rd;
        dec.rs1     = instrQ.rType.rs1;
        dec.rs2     = instrQ.rType.rs2;
        dec.imm     = imm;
        dec.ctrl    = ctrl;
        dec.aluCtrl = aluCtrl;
        // Operands pass straight from the register
        dec.value1  = value1Q;
        dec.value2  = value2Q;
        dec.illegal = illegal;
    end

    // One-cycle operand latency, skipped on the first edge after reset
    value1Latency: assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst) |-> (dec.value1 == $past(rsValue1))
    );

endmodule

// File: verilog/aluDecode.sv
`timescale 1ns/1ps

module aluDecode
    import rv32DecodePkg::*;
(
    input  instrT   word,
    input  aluOpT   aluOp,
    output aluCtrlT aluCtrl
);

    // M extension marker in func7
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic isOp;
    logic isMulDiv;
    logic altOp;

    assign isOp     = (word.rType.opcode == OPC_OP);
    assign isMulDiv = isOp && (word.rType.funct7 == F7_MULDIV);
    // func7 bit 5 flags SUB and SRA
    assign altOp    = word.rType.funct7[5];

    always_comb
    begin
        // Address and link arithmetic default to ADD
        aluCtrl = ALU_ADD;

        case (aluOp)
            // Branch compare is a subtract
            ALUOP_BRANCH:
                aluCtrl = ALU_SUB;
            // Class 0 also comes from the all-zero control of illegal words
            ALUOP_MEM:
            begin
                if (word.rType.opcode != OPC_LOAD && word.rType.opcode != OPC_STORE)
                begin
                    aluCtrl = ALU_AND;
                end
            end
            ALUOP_ARITH:
            begin
                if (isMulDiv)
                begin
                    // MUL group in func3 order
                    unique case (word.rType.funct3)
                        3'b000: aluCtrl = ALU_MUL;
                        3'b001: aluCtrl = ALU_MULH;
                        3'b010: aluCtrl = ALU_MULHSU;
                        3'b011: aluCtrl = ALU_MULHU;
                        3'b100: aluCtrl = ALU_DIV;
                        3'b101: aluCtrl = ALU_DIVU;
                        3'b110: aluCtrl = ALU_REM;
                        default: aluCtrl = ALU_REMU;
                    endcase
                end
                else
                begin
                    unique case (word.rType.funct3)
                        // ADDI has no SUB form
                        3'b000: aluCtrl = (isOp && altOp) ? ALU_SUB : ALU_ADD;
                        3'b001: aluCtrl = ALU_SLL;
                        3'b010: aluCtrl = ALU_SLT;
                        3'b011: aluCtrl = ALU_SLTU;
                        3'b100: aluCtrl = ALU_XOR;
                        // Shift right uses the same bit for SRAI and SRA
                        3'b101: aluCtrl = altOp ? ALU_SRA : ALU_SRL;
                        3'b110: aluCtrl = ALU_OR;
                        default: aluCtrl = ALU_AND;
                    endcase
                end
            end
            default:
                aluCtrl = ALU_ADD;
        endcase
    end

endmodule

// File: verilog/controlDecode.sv
`timescale 1ns/1ps

module controlDecode
    import rv32DecodePkg::*;
(
    input  instrT word,
    output ctrlT  ctrl,
    output logic  illegal
);

    // func7 values accepted on the OP opcode
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    logic opFunct7Ok;

    // Base, SUB/SRA or M extension
    assign opFunct7Ok = (word.rType.funct7 == F7_BASE) ||
                        (word.rType.funct7 == F7_ALT) ||
                        (word.rType.funct7 == F7_MULDIV);

    always_comb
    begin
        // Quiet controls unless an opcode sets them
        ctrl    = '0;
        illegal = 1'b0;

        unique case (word.rType.opcode)
            OPC_LUI:
            begin
                ctrl.aluOp    = ALUOP_LUI;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OPC_AUIPC:
            begin
                ctrl.aluOp    = ALUOP_AUIPC;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Jumps write the link register
            OPC_JAL:
            begin
                ctrl.aluOp    = ALUOP_JAL;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.branch   = 1'b1;
            end
            OPC_JALR:
            begin
                ctrl.aluOp    = ALUOP_JALR;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.branch   = 1'b1;
            end
            // Compare in the ALU, no writeback
            OPC_BRANCH:
            begin
                ctrl.aluOp  = ALUOP_BRANCH;
                ctrl.branch = 1'b1;
            end
            OPC_LOAD:
            begin
                ctrl.aluOp    = ALUOP_MEM;
                ctrl.aluSrc   = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            OPC_STORE:
            begin
                ctrl.aluOp    = ALUOP_MEM;
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OPC_OP_IMM:
            begin
                ctrl.aluOp    = ALUOP_ARITH;
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            // Register-register, base or M
            OPC_OP:
            begin
                if (opFunct7Ok)
                begin
                    ctrl.aluOp    = ALUOP_ARITH;
                    ctrl.regWrite = 1'b1;
                end
                else
                begin
                    illegal = 1'b1;
                end
            end
            // SYSTEM, FENCE and junk all land here
            default:
            begin
                illegal = 1'b1;
            end
        endcase
    end

    // Memory port never asked to read and write at once
    always_comb
    begin
        memExclusive: assert final (!(ctrl.memRead && ctrl.memWrite));
        illegalNoWrite: assert final (!illegal || !ctrl.regWrite);
    end

endmodule

// File: verilog/immGen.sv
`timescale 1ns/1ps

module immGen
    import rv32DecodePkg::*;
(
    input  instrT       word,
    output logic [31:0] imm
);

    // Candidate immediates sign-extended from bit 31
    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immU;
    logic [31:0] immJ;

    // I-format with shifts keeping the raw field
    assign immI = {{20{word.iType.imm[11]}}, word.iType.imm};

    // S-format offset split around rs2
    assign immS = {{20{word.sType.immHi[6]}}, word.sType.immHi, word.sType.immLo};

    // B-format halfword offset
    assign immB = {{19{word.bType.imm12}}, word.bType.imm12, word.bType.imm11,
                   word.bType.immHi, word.bType.immLo, 1'b0};

    // U-format fills the upper 20 bits
    assign immU = {word.uType.imm, 12'b0};

    // J-format halfword offset
    assign immJ = {{11{word.jType.imm20}}, word.jType.imm20, word.jType.immHi,
                   word.jType.imm11, word.jType.immLo, 1'b0};

    // Format select by opcode
    always_comb
    begin
        unique case (word.rType.opcode)
            OPC_JALR, OPC_LOAD, OPC_OP_IMM:
                imm = immI;
            OPC_STORE:
                imm = immS;
            OPC_BRANCH:
                imm = immB;
            OPC_LUI, OPC_AUIPC:
                imm = immU;
            OPC_JAL:
                imm = immJ;
            // OP and anything unknown carry no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

// File: verilog/rv32DecodePkg.sv
package rv32DecodePkg;

    // Major opcodes kept by this decoder
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcodeT;

    // Operation class handed to the ALU decoder
    typedef enum logic [2:0] {
        ALUOP_MEM    = 3'b000,
        ALUOP_BRANCH = 3'b001,
        ALUOP_ARITH  = 3'b010,
        ALUOP_JAL    = 3'b011,
        ALUOP_LUI    = 3'b100,
        ALUOP_AUIPC  = 3'b101,
        ALUOP_JALR   = 3'b111
    } aluOpT;

    // Exact ALU operation, code 5 left unused
    typedef enum logic [4:0] {
        ALU_AND    = 5'd0,
        ALU_OR     = 5'd1,
        ALU_ADD    = 5'd2,
        ALU_XOR    = 5'd3,
        ALU_SUB    = 5'd4,
        ALU_SLL    = 5'd6,
        ALU_SRL    = 5'd7,
        ALU_SRA    = 5'd8,
        ALU_SLT    = 5'd9,
        ALU_SLTU   = 5'd10,
        ALU_MUL    = 5'd11,
        ALU_MULH   = 5'd12,
        ALU_MULHSU = 5'd13,
        ALU_MULHU  = 5'd14,
        ALU_DIV    = 5'd15,
        ALU_DIVU   = 5'd16,
        ALU_REM    = 5'd17,
        ALU_REMU   = 5'd18
    } aluCtrlT;

    // One struct per base instruction format, MSB first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rTypeT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iTypeT;

    // Store offset split around rs1/rs2
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sTypeT;

    // Branch offset bits 12, 10:5, 4:1, 11
    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic       imm11;
        logic [6:0] opcode;
    } bTypeT;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uTypeT;

    // Jump offset bits 20, 10:1, 11, 19:12
    typedef struct packed {
        logic       imm20;
        logic [9:0] immLo;
        logic       imm11;
        logic [7:0] immHi;
        logic [4:0] rd;
        logic [6:0] opcode;
    } jTypeT;

    // Same 32-bit word seen through each format
    typedef union packed {
        rTypeT rType;
        iTypeT iType;
        sTypeT sType;
        bTypeT bType;
        uTypeT uType;
        jTypeT jType;
    } instrT;

    typedef struct packed {
        logic  memWrite;
        logic  memRead;
        logic  regWrite;
        logic  aluSrc;
        aluOpT aluOp;
        logic  branch;
        logic  memToReg;
    } ctrlT;

    // Everything passed on to execute
    typedef struct packed {
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm;
        ctrlT        ctrl;
        aluCtrlT     aluCtrl;
        logic [31:0] value1;
        logic [31:0] value2;
        logic        illegal;
    } decodeOutT;

endpackage
